//--- common/idct_pkg.sv
// Shared widths, cosine weights and vector types; sums stay inside ACC_W only for 16-bit inputs
package idct_pkg;

        // ##############################
        // Widths
        // ##############################

        // Signed input coefficient
        localparam int COEF_W = 16;

        // The largest absolute row sum of the weights is 479, so 9 extra bits are enough
        localparam int ACC_W = 25;

        // Output samples are enough for a rounding shift of 7 or more
        localparam int SAMPLE_W = 18;

        typedef logic signed [COEF_W-1:0] coef_t;
        typedef logic signed [ACC_W-1:0] acc_t;
        typedef logic signed [SAMPLE_W-1:0] sample_t;

        // Indexed by frequency, 0 is DC
        typedef coef_t [7:0] coef_vec_t;

        // Four partial sums from the even or the odd half
        typedef acc_t [3:0] half_vec_t;

        // Indexed by sample position
        typedef sample_t [7:0] sample_vec_t;

        // ##############################
        // Cosine weights
        // ##############################

        // Integer approximations of 64 * sqrt(2) * cos(k * pi / 16)
        localparam acc_t W0 = 25'sd64;
        localparam acc_t W1 = 25'sd89;
        localparam acc_t W2 = 25'sd83;
        localparam acc_t W3 = 25'sd75;
        localparam acc_t W5 = 25'sd50;
        localparam acc_t W6 = 25'sd36;
        localparam acc_t W7 = 25'sd18;

endpackage

//--- idct/idct_even.sv
// Even half of the 8-point inverse DCT; one register stage, inputs must be stable for a cycle
`timescale 1ns/1ps

module idct_even (
        input  logic                  clk,
        input  logic                  reset,
        input  idct_pkg::coef_vec_t   coef_q,
        output idct_pkg::half_vec_t   even
);

        import idct_pkg::*;

        acc_t x0;
        acc_t x2;
        acc_t x4;
        acc_t x6;

        // Terms of the DC and Nyquist rows
        acc_t dc_sum;
        acc_t dc_dif;

        // Terms of rows 2 and 6
        acc_t rot_a;
        acc_t rot_b;

        half_vec_t even_d;

        assign x0 = acc_t'(coef_q[0]);
        assign x2 = acc_t'(coef_q[2]);
        assign x4 = acc_t'(coef_q[4]);
        assign x6 = acc_t'(coef_q[6]);

        assign dc_sum = W0 * (x0 + x4);
        assign dc_dif = W0 * (x0 - x4);
        assign rot_a  = W2 * x2 + W6 * x6;
        assign rot_b  = W6 * x2 - W2 * x6;

        // e0 and e3 pair the outer terms, e1 and e2 the inner ones
        always_comb begin
                even_d[0] = dc_sum + rot_a;
                even_d[1] = dc_dif + rot_b;
                even_d[2] = dc_dif - rot_b;
                even_d[3] = dc_sum - rot_a;
        end

        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        even <= '0;
                end else begin
                        even <= even_d;
                end
        end

endmodule

//--- idct/idct_odd.sv
// Odd half of the 8-point inverse DCT; one register stage, sixteen constant multiplies
`timescale 1ns/1ps

module idct_odd (
        input  logic                  clk,
        input  logic                  reset,
        input  idct_pkg::coef_vec_t   coef_q,
        output idct_pkg::half_vec_t   odd
);

        import idct_pkg::*;

        acc_t x1;
        acc_t x3;
        acc_t x5;
        acc_t x7;

        half_vec_t odd_d;

        assign x1 = acc_t'(coef_q[1]);
        assign x3 = acc_t'(coef_q[3]);
        assign x5 = acc_t'(coef_q[5]);
        assign x7 = acc_t'(coef_q[7]);

        // ##############################
        // Odd rows, one column each
        // ##############################

        // Column n of rows 1, 3, 5 and 7; columns 4 to 7 are the same with the sign flipped,
        // which the butterfly takes care of
        always_comb begin
                odd_d[0] = W1 * x1
                         + W3 * x3
                         + W5 * x5
                         + W7 * x7;

                odd_d[1] = W3 * x1
                         - W7 * x3
                         - W1 * x5
                         - W5 * x7;

                odd_d[2] = W5 * x1
                         - W1 * x3
                         + W7 * x5
                         + W3 * x7;

                odd_d[3] = W7 * x1
                         - W5 * x3
                         + W3 * x5
                         - W1 * x7;
        end

        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        odd <= '0;
                end else begin
                        odd <= odd_d;
                end
        end

endmodule

//--- idct/idct_butterfly.sv
// Final butterfly with round-half-up shift; ROUND_SHIFT below 7 can overflow the output width
`timescale 1ns/1ps

module idct_butterfly #(
        parameter int ROUND_SHIFT = 7
) (
        input  logic                    clk,
        input  logic                    reset,
        input  idct_pkg::half_vec_t     even,
        input  idct_pkg::half_vec_t     odd,
        output idct_pkg::sample_vec_t   samples
);

        import idct_pkg::*;

        // Half of one output step, so the shift rounds to nearest with ties upward
        localparam acc_t ROUND_ADD = acc_t'(1) <<< (ROUND_SHIFT - 1);

        acc_t sum_rnd [4];
        acc_t dif_rnd [4];

        always_comb begin
                for (int k = 0; k < 4; k++) begin
                        sum_rnd[k] = even[k] + odd[k] + ROUND_ADD;
                        dif_rnd[k] = even[k] - odd[k] + ROUND_ADD;
                end
        end

        // ##############################
        // Output register
        // ##############################

        // Sample k takes the sum, its mirror 7-k the difference
        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        samples <= '0;
                end else begin
                        for (int k = 0; k < 4; k++) begin
                                samples[k]     <= sample_t'(sum_rnd[k] >>> ROUND_SHIFT);
                                samples[7 - k] <= sample_t'(dif_rnd[k] >>> ROUND_SHIFT);
                        end
                end
        end

endmodule

//--- source/idct_flow_ctrl.sv
// Four-phase handshakes on both sides; only one vector is in flight until its output is handed off
`timescale 1ns/1ps

module idct_flow_ctrl (
        input  logic                  clk,
        input  logic                  reset,
        input  logic                  in_req,
        input  idct_pkg::coef_vec_t   coef,
        input  logic                  out_ack,
        output logic                  in_ack,
        output logic                  out_req,
        output idct_pkg::coef_vec_t   coef_q
);

        // Edges from capture to out_req: even/odd, butterfly, then the request itself
        localparam logic [1:0] LATENCY = 2'd3;

        // Edges left until the result is at the butterfly output
        logic [1:0] lat_cnt;

        logic out_idle;
        logic capture;

        // The output side counts as busy while a vector is still in the datapath,
        // otherwise a new capture could change samples under a raised out_req
        assign out_idle = !out_req && !out_ack && (lat_cnt == 2'd0);

        assign capture = in_req && !in_ack && out_idle;

        // ##############################
        // Input side
        // ##############################

        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        in_ack <= 1'b0;
                end else if (capture) begin
                        in_ack <= 1'b1;
                end else if (in_ack && !in_req) begin
                        in_ack <= 1'b0;
                end
        end

        // Held for the whole transform so the free-running datapath keeps its result
        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        coef_q <= '0;
                end else if (capture) begin
                        coef_q <= coef;
                end
        end

        // ##############################
        // Latency and output side
        // ##############################

        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        lat_cnt <= 2'd0;
                end else if (capture) begin
                        lat_cnt <= LATENCY;
                end else if (lat_cnt != 2'd0) begin
                        lat_cnt <= lat_cnt - 2'd1;
                end
        end

        // Raised on the edge that empties the counter, dropped once out_ack is seen
        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        out_req <= 1'b0;
                end else if (lat_cnt == 2'd1) begin
                        out_req <= 1'b1;
                end else if (out_req && out_ack) begin
                        out_req <= 1'b0;
                end
        end

endmodule

//--- source/idct8_top.sv
// One-pass 8-point inverse DCT; ROUND_SHIFT 7 for columns, 12 for rows, result 3 cycles after capture
`timescale 1ns/1ps

module idct8_top #(
        parameter int ROUND_SHIFT = 7
) (
        input  logic                    clk,
        input  logic                    reset,
        input  logic                    in_req,
        input  idct_pkg::coef_vec_t     coef,
        input  logic                    out_ack,
        output logic                    in_ack,
        output logic                    out_req,
        output idct_pkg::sample_vec_t   samples
);

        import idct_pkg::*;

        coef_vec_t coef_q;
        half_vec_t even;
        half_vec_t odd;

        idct_flow_ctrl idct_flow_ctrl_inst (
                .clk     (clk),
                .reset   (reset),
                .in_req  (in_req),
                .coef    (coef),
                .out_ack (out_ack),
                .in_ack  (in_ack),
                .out_req (out_req),
                .coef_q  (coef_q)
        );

        // ##############################
        // Datapath
        // ##############################

        idct_even idct_even_inst (
                .clk    (clk),
                .reset  (reset),
                .coef_q (coef_q),
                .even   (even)
        );

        idct_odd idct_odd_inst (
                .clk    (clk),
                .reset  (reset),
                .coef_q (coef_q),
                .odd    (odd)
        );

        idct_butterfly #(
                .ROUND_SHIFT (ROUND_SHIFT)
        ) idct_butterfly_inst (
                .clk     (clk),
                .reset   (reset),
                .even    (even),
                .odd     (odd),
                .samples (samples)
        );

endmodule

//--- sim/idct8_assert.sv
// Bound checker for idct8_top; its reference model assumes the default ROUND_SHIFT of 7
`timescale 1ns/1ps

module idct8_assert (
        input logic                    clk,
        input logic                    reset,
        input logic                    in_req,
        input idct_pkg::coef_vec_t     coef,
        input logic                    in_ack,
        input logic                    out_req,
        input logic                    out_ack,
        input idct_pkg::sample_vec_t   samples
);

        import idct_pkg::*;

        localparam int SHIFT = 7;

        // Weight of coefficient k (row) in output sample n (column)
        localparam int C_MAT [8][8] = '{
                '{64,  64,  64,  64,  64,  64,  64,  64},
                '{89,  75,  50,  18, -18, -50, -75, -89},
                '{83,  36, -36, -83, -83, -36,  36,  83},
                '{75, -18, -89, -50,  50,  89,  18, -75},
                '{64, -64, -64,  64,  64, -64, -64,  64},
                '{50, -89,  18,  75, -75, -18,  89, -50},
                '{36, -83,  83, -36, -36,  83, -83,  36},
                '{18, -50,  75, -89,  89, -75,  50, -18}
        };

        int fail_count = 0;

        logic        in_ack_d;
        logic        seen_req;
        coef_vec_t   coef_d;
        sample_vec_t exp_vec;

        // Full matrix product, then round half up and shift
        function automatic sample_vec_t ref_idct(input coef_vec_t x);
                longint      acc;
                sample_vec_t res;
                for (int n = 0; n < 8; n++) begin
                        acc = longint'(1) <<< (SHIFT - 1);
                        for (int k = 0; k < 8; k++) begin
                                acc += longint'(C_MAT[k][n]) * longint'(x[k]);
                        end
                        res[n] = sample_t'(acc >>> SHIFT);
                end
                return res;
        endfunction

        // ##############################
        // Reference model
        // ##############################

        // coef_d still holds the vector from the capturing edge when in_ack is first seen high
        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        in_ack_d <= 1'b0;
                        seen_req <= 1'b0;
                        coef_d   <= '0;
                        exp_vec  <= '0;
                end else begin
                        in_ack_d <= in_ack;
                        coef_d   <= coef;
                        if (in_req) begin
                                seen_req <= 1'b1;
                        end
                        if (in_ack && !in_ack_d) begin
                                exp_vec <= ref_idct(coef_d);
                        end
                end
        end

        // ##############################
        // Assertions
        // ##############################

        idle_after_reset: assert property (@(posedge clk) disable iff (reset)
                !seen_req |-> !in_ack && !out_req)
        else begin
                $error("error in_ack = %h, out_req = %h before any in_req",
                       $sampled(in_ack), $sampled(out_req));
                fail_count++;
        end

        result_matches: assert property (@(posedge clk) disable iff (reset)
                out_req |-> samples == exp_vec)
        else begin
                $error("error samples = %h, expected %h", $sampled(samples), $sampled(exp_vec));
                fail_count++;
        end

        ack_rise_with_req: assert property (@(posedge clk) disable iff (reset)
                $rose(in_ack) |-> $past(in_req))
        else begin
                $error("error in_ack rose without a pending in_req");
                fail_count++;
        end

        ack_fall_after_req: assert property (@(posedge clk) disable iff (reset)
                $fell(in_ack) |-> !$past(in_req))
        else begin
                $error("error in_ack fell while in_req was still high");
                fail_count++;
        end

        output_holds: assert property (@(posedge clk) disable iff (reset)
                out_req && !out_ack |=> out_req && $stable(samples))
        else begin
                $error("error out_req = %h, samples = %h changed before out_ack",
                       $sampled(out_req), $sampled(samples));
                fail_count++;
        end

        no_capture_when_busy: assert property (@(posedge clk) disable iff (reset)
                $rose(in_ack) |-> $past(!out_req && !out_ack))
        else begin
                $error("error a vector was captured while the output side was busy");
                fail_count++;
        end

        fixed_latency: assert property (@(posedge clk) disable iff (reset)
                $rose(in_ack) |-> ##3 $rose(out_req))
        else begin
                $error("error out_req did not rise three edges after in_ack");
                fail_count++;
        end

endmodule

//--- sim/idct8_tb.sv
// Testbench for idct8_top at the default ROUND_SHIFT; the bound checker does all result checks
`timescale 1ns/1ps

module idct8_tb;

        import idct_pkg::*;

        localparam int N_DC     = 10;
        localparam int N_EXTR   = 256;
        localparam int N_RAND   = 150;
        localparam int N_VEC    = N_DC + N_EXTR + N_RAND;
        localparam int CLK_NS   = 20;

        // Each vector needs well under 20 cycles even with the longest out_ack delay
        localparam time WATCHDOG_NS = N_VEC * 20 * CLK_NS + 200 * CLK_NS;

        logic        clk = 1'b0;
        logic        reset;
        logic        in_req;
        coef_vec_t   coef;
        logic        out_ack;
        logic        in_ack;
        logic        out_req;
        sample_vec_t samples;

        int seed = 32'h13e46cba;
        int delay_seed;
        int done_cnt = 0;

        idct8_top idct8_top_inst (
                .clk     (clk),
                .reset   (reset),
                .in_req  (in_req),
                .coef    (coef),
                .out_ack (out_ack),
                .in_ack  (in_ack),
                .out_req (out_req),
                .samples (samples)
        );

        bind idct8_top idct8_assert idct8_assert_inst (
                .clk     (clk),
                .reset   (reset),
                .in_req  (in_req),
                .coef    (coef),
                .in_ack  (in_ack),
                .out_req (out_req),
                .out_ack (out_ack),
                .samples (samples)
        );

        always #(CLK_NS / 2) clk = ~clk;

        function automatic coef_vec_t dc_vector(input coef_t v);
                coef_vec_t x;
                x    = '0;
                x[0] = v;
                return x;
        endfunction

        // Bit k of the pattern picks the negative extreme for coefficient k
        function automatic coef_vec_t extreme_vector(input logic [7:0] pattern);
                coef_vec_t x;
                for (int k = 0; k < 8; k++) begin
                        x[k] = pattern[k] ? coef_t'(-32768) : coef_t'(32767);
                end
                return x;
        endfunction

        // Full four-phase cycle on the input side
        task automatic send_vector(input coef_vec_t v);
                @(posedge clk);
                coef   <= v;
                in_req <= 1'b1;
                do @(posedge clk); while (!in_ack);
                in_req <= 1'b0;
                do @(posedge clk); while (in_ack);
        endtask

        // ##############################
        // Consumer with random delays
        // ##############################

        initial begin : consumer
                int delay;
                forever begin
                        @(posedge clk);
                        if (!reset && out_req && !out_ack) begin
                                delay = $unsigned($random(delay_seed)) % 6;
                                repeat (delay) @(posedge clk);
                                out_ack <= 1'b1;
                                do @(posedge clk); while (out_req);
                                out_ack <= 1'b0;
                                done_cnt++;
                        end
                end
        end

        always @(posedge clk) begin
                if (idct8_top_inst.idct8_assert_inst.fail_count != 0) begin
                        $display("TESTBENCH FAILED");
                        $fatal(1, "an assertion in the checker failed");
                end
        end

        initial begin : watchdog
                #(WATCHDOG_NS);
                $display("TESTBENCH FAILED");
                $fatal(1, "timeout, not all vectors came back within %0t", WATCHDOG_NS);
        end

        // ##############################
        // Stimulus
        // ##############################

        initial begin : stimulus
                coef_t dc_vals [N_DC];
                coef_vec_t x;
                dc_vals = '{16'sd0, 16'sd1, -16'sd1, 16'sd63, 16'sd64,
                            -16'sd64, 16'sd100, -16'sd100, 16'sd32767, -16'sd32768};
                reset      = 1'b1;
                in_req     = 1'b0;
                coef       = '0;
                out_ack    = 1'b0;
                delay_seed = $random(seed);
                repeat (4) @(posedge clk);
                reset <= 1'b0;

                // A few idle cycles so the outputs are seen low before any request
                repeat (3) @(posedge clk);

                for (int i = 0; i < N_DC; i++) begin
                        send_vector(dc_vector(dc_vals[i]));
                end
                for (int p = 0; p < N_EXTR; p++) begin
                        send_vector(extreme_vector(p[7:0]));
                end
                for (int i = 0; i < N_RAND; i++) begin
                        for (int k = 0; k < 8; k++) begin
                                x[k] = coef_t'($random(seed));
                        end
                        send_vector(x);
                end

                while (done_cnt < N_VEC) @(posedge clk);
                repeat (4) @(posedge clk);

                if (idct8_top_inst.idct8_assert_inst.fail_count != 0) begin
                        $display("TESTBENCH FAILED");
                        $fatal(1, "the checker reported failures");
                end else begin
                        $display("TESTBENCH PASSED");
                        $finish;
                end
        end

endmodule

//--- compile.f
common/idct_pkg.sv
idct/idct_even.sv
idct/idct_odd.sv
idct/idct_butterfly.sv
source/idct_flow_ctrl.sv
source/idct8_top.sv
sim/idct8_assert.sv
sim/idct8_tb.sv
